/* ctrl_pkg.sv */
// PS/2 set 2 scan codes without the E0 prefix, so extended keys alias their keypad twins
package ctrl_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Port widths and board count
  ////////////////////////////////////////////////////////////////////////////

  localparam int JOY_W      = 32;
  localparam int STATUS_W   = 32;
  localparam int AR_W       = 13;
  localparam int GAME_COUNT = 7;

  // Raw PS/2 event as delivered by the host, toggle flips once per event
  typedef struct packed {
    logic       toggle;
    logic       pressed;
    logic       spare;
    logic [7:0] code;
  } ps2_key_t;

  // One player's controls as seen by the core
  typedef struct packed {
    logic       up;
    logic       down;
    logic       left;
    logic       right;
    logic [3:0] buttons;   // Bit 0 is button 1
    logic       start;
    logic       coin;
    logic       pause;
  } player_t;

  // Core options decoded from the menu status word
  typedef struct packed {
    logic [3:0] offset_x;
    logic [3:0] offset_y;
    logic       rotate;
    logic       flip;
    logic       compatibility;
    logic       service;
    logic       sdram;
    logic [3:0] layer_enable;  // Sprite in bit 0, then layers 0 to 2
    logic       row_scroll_en;
    logic       row_select_en;
    logic       fb_sprite_en;
    logic       fb_system_en;
    logic [3:0] game_index;
  } options_t;

  ////////////////////////////////////////////////////////////////////////////
  // Key table
  ////////////////////////////////////////////////////////////////////////////

  localparam logic [7:0] KEY_UP    = 8'h75;
  localparam logic [7:0] KEY_DOWN  = 8'h72;
  localparam logic [7:0] KEY_LEFT  = 8'h6B;
  localparam logic [7:0] KEY_RIGHT = 8'h74;
  localparam logic [7:0] KEY_CTRL  = 8'h14;
  localparam logic [7:0] KEY_ALT   = 8'h11;
  localparam logic [7:0] KEY_SHIFT = 8'h12;
  localparam logic [7:0] KEY_SPACE = 8'h29;
  localparam logic [7:0] KEY_1     = 8'h16;
  localparam logic [7:0] KEY_2     = 8'h1E;
  localparam logic [7:0] KEY_5     = 8'h2E;
  localparam logic [7:0] KEY_6     = 8'h36;
  localparam logic [7:0] KEY_A     = 8'h1C;
  localparam logic [7:0] KEY_S     = 8'h1B;
  localparam logic [7:0] KEY_Q     = 8'h15;
  localparam logic [7:0] KEY_R     = 8'h2D;
  localparam logic [7:0] KEY_F     = 8'h2B;
  localparam logic [7:0] KEY_D     = 8'h23;
  localparam logic [7:0] KEY_G     = 8'h34;
  localparam logic [7:0] KEY_P     = 8'h4D;
  localparam logic [7:0] KEY_W     = 8'h1D;

endpackage

/* pll_lock_watch.sv */
// Lock glitches shorter than one clk_sys period may go unseen and HOLD_CYCLES must be at least 1
`timescale 1ns/1ps

module pll_lock_watch #(
  parameter int HOLD_CYCLES = 256
) (
  input  logic clk_sys,
  input  logic RESET,
  input  logic pll_locked,
  output logic rst_pll
);

  // Counter only needs to reach HOLD_CYCLES-1
  localparam int CNT_W = (HOLD_CYCLES > 1) ? $clog2(HOLD_CYCLES) : 1;

  logic             locked_q;
  logic [CNT_W-1:0] hold_cnt;
  logic             lock_lost;

  // Falling edge of lock
  assign lock_lost = locked_q & ~pll_locked;

  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      locked_q <= 1'b0;
      hold_cnt <= '0;
      rst_pll  <= 1'b0;
    end else begin
      locked_q <= pll_locked;
      if (lock_lost) begin
        // Restart the hold on every new loss
        hold_cnt <= CNT_W'(HOLD_CYCLES - 1);
        rst_pll  <= 1'b1;
      end else if (hold_cnt != '0) begin
        hold_cnt <= hold_cnt - 1'b1;
      end else begin
        rst_pll <= 1'b0;
      end
    end
  end

  // Hold counter running means PLL reset asserted
  a_hold_rst : assert property (@(posedge clk_sys) disable iff (RESET)
    (hold_cnt != '0) |-> rst_pll);

endmodule

/* reset_sync.sv */
// Input must be free of glitches since any pulse asserts the output at once and STAGES is at least 2
`timescale 1ns/1ps

module reset_sync #(
  parameter int STAGES = 4
) (
  input  logic clk_sys,
  input  logic rst_in,
  output logic rst_out
);

  logic [STAGES-1:0] chain;

  // Preset on rst_in, then zeros shift through
  always_ff @(posedge clk_sys or posedge rst_in) begin
    if (rst_in) begin
      chain <= '1;
    end else begin
      chain <= {chain[STAGES-2:0], 1'b0};
    end
  end

  // Last stage drives the synchronized reset
  assign rst_out = chain[STAGES-1];

  // Output never lags a held input
  a_rst_follow : assert property (@(posedge clk_sys) rst_in |-> rst_out);

endmodule

/* player_input.sv */
// Keys are tracked without the E0 prefix and only joystick bits 10 to 0 reach the players
`timescale 1ns/1ps

module player_input import ctrl_pkg::*; (
  input  logic             clk_sys,
  input  logic             RESET,
  input  ps2_key_t         ps2_key,
  input  logic [JOY_W-1:0] joystick_0,
  input  logic [JOY_W-1:0] joystick_1,
  output player_t          player_0,
  output player_t          player_1
);

  // One bit per key in the table
  typedef struct packed {
    logic up, down, left, right;
    logic ctrl, alt, space, shift;
    logic k1, k5, p;
    logic r, f, d, g;
    logic a, s, q, w;
    logic k2, k6;
  } keys_t;

  logic    toggle_q;
  keys_t   keys;
  player_t key_p0;
  player_t key_p1;

  // Joystick word to player record
  function automatic player_t joy_map(input logic [10:0] joy);
    player_t p;
    p.right   = joy[0];
    p.left    = joy[1];
    p.down    = joy[2];
    p.up      = joy[3];
    p.buttons = joy[7:4];
    p.start   = joy[8];
    p.coin    = joy[9];
    p.pause   = joy[10];
    return p;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Key state
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      toggle_q <= 1'b0;
      keys     <= '0;
    end else begin
      toggle_q <= ps2_key.toggle;
      // New event only on a toggle change
      if (ps2_key.toggle != toggle_q) begin
        case (ps2_key.code)
          KEY_UP:    keys.up    <= ps2_key.pressed;
          KEY_DOWN:  keys.down  <= ps2_key.pressed;
          KEY_LEFT:  keys.left  <= ps2_key.pressed;
          KEY_RIGHT: keys.right <= ps2_key.pressed;
          KEY_CTRL:  keys.ctrl  <= ps2_key.pressed;
          KEY_ALT:   keys.alt   <= ps2_key.pressed;
          KEY_SPACE: keys.space <= ps2_key.pressed;
          KEY_SHIFT: keys.shift <= ps2_key.pressed;
          KEY_1:     keys.k1    <= ps2_key.pressed;
          KEY_5:     keys.k5    <= ps2_key.pressed;
          KEY_P:     keys.p     <= ps2_key.pressed;
          KEY_R:     keys.r     <= ps2_key.pressed;
          KEY_F:     keys.f     <= ps2_key.pressed;
          KEY_D:     keys.d     <= ps2_key.pressed;
          KEY_G:     keys.g     <= ps2_key.pressed;
          KEY_A:     keys.a     <= ps2_key.pressed;
          KEY_S:     keys.s     <= ps2_key.pressed;
          KEY_Q:     keys.q     <= ps2_key.pressed;
          KEY_W:     keys.w     <= ps2_key.pressed;
          KEY_2:     keys.k2    <= ps2_key.pressed;
          KEY_6:     keys.k6    <= ps2_key.pressed;
          default:   ;  // Unknown code ignored
        endcase
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Merge with joysticks
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    // Player 0 on arrows and left-hand modifiers
    key_p0.up      = keys.up;
    key_p0.down    = keys.down;
    key_p0.left    = keys.left;
    key_p0.right   = keys.right;
    key_p0.buttons = {keys.shift, keys.space, keys.alt, keys.ctrl};
    key_p0.start   = keys.k1;
    key_p0.coin    = keys.k5;
    key_p0.pause   = keys.p;
    // Player 1 on RDFG cluster, no pause key
    key_p1.up      = keys.r;
    key_p1.down    = keys.f;
    key_p1.left    = keys.d;
    key_p1.right   = keys.g;
    key_p1.buttons = {keys.w, keys.q, keys.s, keys.a};
    key_p1.start   = keys.k2;
    key_p1.coin    = keys.k6;
    key_p1.pause   = 1'b0;
  end

  assign player_0 = key_p0 | joy_map(joystick_0[10:0]);
  assign player_1 = key_p1 | joy_map(joystick_1[10:0]);

endmodule

/* option_decode.sv */
// Outputs lag the status word by one cycle and a game_index of GAME_COUNT or more is unsupported
`timescale 1ns/1ps

module option_decode import ctrl_pkg::*; (
  input  logic                clk_sys,
  input  logic                RESET,
  input  logic [STATUS_W-1:0] status,
  input  logic [1:0]          buttons,
  input  logic                forced_scandoubler,
  input  logic [1:0]          sdram_sz,
  output options_t            options,
  output logic [AR_W-1:0]     video_arx,
  output logic [AR_W-1:0]     video_ary,
  output logic [1:0]          vga_sl,
  output logic                scandoubler,
  output logic                hq2x,
  output logic                cpu_reset_req
);

  logic [1:0]      aspect;
  logic [2:0]      fx;
  logic [2:0]      sl_d;
  options_t        opt_d;
  logic [AR_W-1:0] arx_d;
  logic [AR_W-1:0] ary_d;

  ////////////////////////////////////////////////////////////////////////////
  // Field decode
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    aspect = status[2:1];
    fx     = status[7:5];
    opt_d.offset_x      = status[27:24];
    opt_d.offset_y      = status[31:28];
    opt_d.rotate        = status[3];
    opt_d.flip          = status[4];
    opt_d.compatibility = status[8];
    opt_d.service       = status[9];
    opt_d.sdram         = |sdram_sz;
    // Menu bits are disables
    opt_d.layer_enable  = ~status[13:10];
    opt_d.row_scroll_en = ~status[14];
    opt_d.row_select_en = ~status[15];
    opt_d.fb_sprite_en  = ~status[16];
    opt_d.fb_system_en  = ~status[17];
    opt_d.game_index    = status[21:18];
    // Original ratio follows rotation, others are preset ARC slots
    if (aspect == 2'd0) begin
      arx_d = opt_d.rotate ? AR_W'(3) : AR_W'(4);
      ary_d = opt_d.rotate ? AR_W'(4) : AR_W'(3);
    end else begin
      arx_d = AR_W'(aspect) - AR_W'(1);
      ary_d = '0;
    end
    // Scanline level from fx, HQ2x gives none
    sl_d = (fx != 3'd0) ? fx - 3'd1 : 3'd0;
  end

  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      options       <= '0;
      video_arx     <= AR_W'(4);
      video_ary     <= AR_W'(3);
      vga_sl        <= 2'd0;
      scandoubler   <= 1'b0;
      hq2x          <= 1'b0;
      cpu_reset_req <= 1'b0;
    end else begin
      options       <= opt_d;
      video_arx     <= arx_d;
      video_ary     <= ary_d;
      vga_sl        <= sl_d[1:0];
      scandoubler   <= (fx != 3'd0) | forced_scandoubler;
      hq2x          <= (fx == 3'd1);
      cpu_reset_req <= status[0] | buttons[1];  // Menu reset or user button
    end
  end

  // Board select stays within the supported set
  a_game_range : assert property (@(posedge clk_sys) disable iff (RESET)
    options.game_index < GAME_COUNT);

endmodule

/* core_ctrl_top.sv */
// pll_locked is taken without a synchronizer and must be stable around clk_sys edges
`timescale 1ns/1ps

module core_ctrl_top import ctrl_pkg::*; #(
  parameter int HOLD_CYCLES = 256,
  parameter int STAGES      = 4
) (
  input  logic                clk_sys,
  input  logic                RESET,
  input  logic                pll_locked,
  input  ps2_key_t            ps2_key,
  input  logic [JOY_W-1:0]    joystick_0,
  input  logic [JOY_W-1:0]    joystick_1,
  input  logic [STATUS_W-1:0] status,
  input  logic [1:0]          buttons,
  input  logic                forced_scandoubler,
  input  logic [1:0]          sdram_sz,
  output logic                rst_pll,
  output logic                rst_sys,
  output logic                rst_cpu,
  output player_t             player_0,
  output player_t             player_1,
  output options_t            options,
  output logic [AR_W-1:0]     video_arx,
  output logic [AR_W-1:0]     video_ary,
  output logic [1:0]          vga_sl,
  output logic                scandoubler,
  output logic                hq2x
);

  logic sys_rst_in;
  logic cpu_rst_in;
  logic cpu_reset_req;

  ////////////////////////////////////////////////////////////////////////////
  // Clock and reset
  ////////////////////////////////////////////////////////////////////////////

  pll_lock_watch #(.HOLD_CYCLES(HOLD_CYCLES)) u_pll_lock_watch (
    .clk_sys    (clk_sys),
    .RESET      (RESET),
    .pll_locked (pll_locked),
    .rst_pll    (rst_pll)
  );

  // CPU reset also covers menu and button requests
  assign sys_rst_in = RESET | ~pll_locked;
  assign cpu_rst_in = sys_rst_in | cpu_reset_req;

  reset_sync #(.STAGES(STAGES)) u_sys_rst (
    .clk_sys (clk_sys),
    .rst_in  (sys_rst_in),
    .rst_out (rst_sys)
  );

  reset_sync #(.STAGES(STAGES)) u_cpu_rst (
    .clk_sys (clk_sys),
    .rst_in  (cpu_rst_in),
    .rst_out (rst_cpu)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Controls and options
  ////////////////////////////////////////////////////////////////////////////

  player_input u_player_input (
    .clk_sys    (clk_sys),
    .RESET      (RESET),
    .ps2_key    (ps2_key),
    .joystick_0 (joystick_0),
    .joystick_1 (joystick_1),
    .player_0   (player_0),
    .player_1   (player_1)
  );

  option_decode u_option_decode (
    .clk_sys            (clk_sys),
    .RESET              (RESET),
    .status             (status),
    .buttons            (buttons),
    .forced_scandoubler (forced_scandoubler),
    .sdram_sz           (sdram_sz),
    .options            (options),
    .video_arx          (video_arx),
    .video_ary          (video_ary),
    .vga_sl             (vga_sl),
    .scandoubler        (scandoubler),
    .hq2x               (hq2x),
    .cpu_reset_req      (cpu_reset_req)
  );

endmodule

/* tb_core_ctrl.sv */
// Expects HOLD_CYCLES of 256 and STAGES of 4 and never drives a game_index above 6
`timescale 1ns/1ps

module tb_core_ctrl import ctrl_pkg::*; ();

  localparam int HOLD_CYCLES    = 256;
  localparam int STAGES         = 4;
  localparam int TIMEOUT_CYCLES = 6000;
  localparam logic [7:0] KEY_LIST [21] = '{KEY_UP, KEY_DOWN, KEY_LEFT, KEY_RIGHT, KEY_CTRL,
    KEY_ALT, KEY_SPACE, KEY_SHIFT, KEY_1, KEY_5, KEY_P, KEY_R, KEY_F, KEY_D, KEY_G, KEY_A,
    KEY_S, KEY_Q, KEY_W, KEY_2, KEY_6};

  logic clk_sys, RESET, pll_locked, forced_scandoubler;
  ps2_key_t ps2_key;
  logic [JOY_W-1:0] joystick_0, joystick_1;
  logic [STATUS_W-1:0] status;
  logic [1:0] buttons, sdram_sz, vga_sl;
  logic rst_pll, rst_sys, rst_cpu, scandoubler, hq2x;
  player_t player_0, player_1;
  options_t options;
  logic [AR_W-1:0] video_arx, video_ary;
  logic [15:0] lfsr_q = 16'd25776;
  logic tgl = 1'b0;
  int cycle_cnt = 0;

  core_ctrl_top #(.HOLD_CYCLES(HOLD_CYCLES), .STAGES(STAGES)) u_core_ctrl_top (.*);

  initial begin
    clk_sys = 1'b0;
    forever #50 clk_sys = ~clk_sys;
  end

  // Run length guard
  always @(posedge clk_sys) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles with tests still running", cycle_cnt);
      abort_run();
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic abort_run();
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("[FAIL] %0t ns %s got %0h expected %0h", $time, name, got, exp);
      abort_run();
    end
  endtask

  // Inputs change 10 ns after the edge
  task automatic next_cycle();
    @(posedge clk_sys);
    #10;
  endtask

  // Fibonacci taps 16 14 13 11 stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic fb;
    r = '0;
    for (int b = 0; b < n; b++) begin
      fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      r[b] = fb;
    end
    return r;
  endfunction

  // Player field that a key drives on its own side
  function automatic player_t key_field(input logic [7:0] code);
    player_t p;
    p = '0;
    case (code)
      KEY_UP, KEY_R:    p.up = 1'b1;
      KEY_DOWN, KEY_F:  p.down = 1'b1;
      KEY_LEFT, KEY_D:  p.left = 1'b1;
      KEY_RIGHT, KEY_G: p.right = 1'b1;
      KEY_CTRL, KEY_A:  p.buttons[0] = 1'b1;
      KEY_ALT, KEY_S:   p.buttons[1] = 1'b1;
      KEY_SPACE, KEY_Q: p.buttons[2] = 1'b1;
      KEY_SHIFT, KEY_W: p.buttons[3] = 1'b1;
      KEY_1, KEY_2:     p.start = 1'b1;
      KEY_5, KEY_6:     p.coin = 1'b1;
      KEY_P:            p.pause = 1'b1;
      default:          p = '0;
    endcase
    return p;
  endfunction

  function automatic player_t joy_expect(input logic [31:0] j);
    player_t p;
    p.right   = j[0];
    p.left    = j[1];
    p.down    = j[2];
    p.up      = j[3];
    p.buttons = j[7:4];
    p.start   = j[8];
    p.coin    = j[9];
    p.pause   = j[10];
    return p;
  endfunction

  task automatic send_key(input logic flip, input logic pressed, input logic [7:0] code);
    if (flip) tgl = ~tgl;
    ps2_key.toggle  = tgl;
    ps2_key.pressed = pressed;
    ps2_key.spare   = 1'b0;
    ps2_key.code    = code;
  endtask

  task automatic check_players(input player_t e0, input player_t e1);
    check_val("player_0", 32'(player_0), 32'(e0));
    check_val("player_1", 32'(player_1), 32'(e1));
  endtask

  // rst_cpu must reach level while rst_sys stays low
  task automatic wait_cpu_level(input logic level, input int limit);
    int n;
    n = 0;
    while (rst_cpu !== level && n < limit) begin
      next_cycle();
      n++;
      check_val("rst_sys", 32'(rst_sys), 32'd0);
    end
    assert (rst_cpu === level) else begin
      $display("rst_cpu did not reach %0b within %0d cycles", level, limit);
      abort_run();
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic reset_release_test();
    int n;
    check_players('0, '0);
    check_val("options", 32'(options), 32'd0);
    check_val("video_arx", 32'(video_arx), 32'd4);
    check_val("video_ary", 32'(video_ary), 32'd3);
    check_val("vga_sl", 32'(vga_sl), 32'd0);
    check_val("scandoubler", 32'(scandoubler), 32'd0);
    check_val("hq2x", 32'(hq2x), 32'd0);
    // Both synchronized resets held while RESET is high
    check_val("rst_sys", 32'(rst_sys), 32'd1);
    check_val("rst_cpu", 32'(rst_cpu), 32'd1);
    check_val("rst_pll", 32'(rst_pll), 32'd0);
    RESET = 1'b0;
    n = 0;
    while ((rst_sys !== 1'b0 || rst_cpu !== 1'b0) && n < STAGES + 1) begin
      next_cycle();
      n++;
      check_val("rst_pll", 32'(rst_pll), 32'd0);
    end
    assert (rst_sys === 1'b0 && rst_cpu === 1'b0) else begin
      $display("System or CPU reset still high %0d cycles after RESET fell", n);
      abort_run();
    end
  endtask

  task automatic lock_loss_test();
    int hold;
    pll_locked = 1'b0;
    next_cycle();
    check_val("rst_sys", 32'(rst_sys), 32'd1);
    repeat (2) next_cycle();
    check_val("rst_pll", 32'(rst_pll), 32'd1);
    pll_locked = 1'b1;
    // Three high samples so far
    hold = 3;
    do begin
      next_cycle();
      if (rst_pll === 1'b1) hold++;
    end while (rst_pll === 1'b1 && hold < 300);
    assert (hold >= HOLD_CYCLES - 1 && hold <= HOLD_CYCLES + 1) else begin
      $display("PLL reset held for %0d cycles instead of about %0d", hold, HOLD_CYCLES);
      abort_run();
    end
    check_val("rst_sys", 32'(rst_sys), 32'd0);
  endtask

  task automatic key_test();
    player_t fld;
    player_t e0;
    player_t e1;
    for (int i = 0; i < 21; i++) begin
      fld = key_field(KEY_LIST[i]);
      e0  = (i < 11) ? fld : player_t'(0);
      e1  = (i < 11) ? player_t'(0) : fld;
      send_key(1'b1, 1'b1, KEY_LIST[i]);
      next_cycle();
      check_players(e0, e1);
      // Stale toggle and unknown code leave the key pressed
      send_key(1'b0, 1'b0, KEY_LIST[i]);
      next_cycle();
      check_players(e0, e1);
      send_key(1'b1, 1'b0, 8'h0E);
      next_cycle();
      check_players(e0, e1);
      send_key(1'b1, 1'b0, KEY_LIST[i]);
      next_cycle();
      check_players('0, '0);
    end
  endtask

  task automatic joystick_test();
    logic [31:0] j0;
    logic [31:0] j1;
    for (int i = 0; i < 21; i++) begin
      j0 = (i < 20) ? rand_bits(32) : 32'hFFFF_F800;
      j1 = (i < 20) ? rand_bits(32) : 32'hFFFF_F800;
      joystick_0 = j0;
      joystick_1 = j1;
      next_cycle();
      check_players(joy_expect(j0), joy_expect(j1));
    end
    joystick_0 = '0;
    joystick_1 = '0;
  endtask

  task automatic options_test();
    logic [31:0] st;
    logic [31:0] tmp;
    logic [31:0] earx;
    logic [31:0] eary;
    logic [2:0] fx;
    options_t eo;
    for (int i = 0; i < 20; i++) begin
      st = rand_bits(32);
      st[0] = 1'b0;
      if (st[21:18] > 4'd6) st[21:18] = st[21:18] & 4'd3;
      status = st;
      tmp = rand_bits(2);
      sdram_sz = tmp[1:0];
      tmp = rand_bits(1);
      forced_scandoubler = tmp[0];
      next_cycle();
      eo.offset_x      = st[27:24];
      eo.offset_y      = st[31:28];
      eo.rotate        = st[3];
      eo.flip          = st[4];
      eo.compatibility = st[8];
      eo.service       = st[9];
      eo.sdram         = (sdram_sz != 2'b00);
      eo.layer_enable  = ~st[13:10];
      eo.row_scroll_en = ~st[14];
      eo.row_select_en = ~st[15];
      eo.fb_sprite_en  = ~st[16];
      eo.fb_system_en  = ~st[17];
      eo.game_index    = st[21:18];
      // Ratio 0 is 4:3 turned by rotate
      earx = (st[2:1] == 2'd0) ? (st[3] ? 32'd3 : 32'd4) : 32'(st[2:1]) - 32'd1;
      eary = (st[2:1] == 2'd0) ? (st[3] ? 32'd4 : 32'd3) : 32'd0;
      fx = st[7:5];
      check_val("options", 32'(options), 32'(eo));
      check_val("video_arx", 32'(video_arx), earx);
      check_val("video_ary", 32'(video_ary), eary);
      check_val("vga_sl", 32'(vga_sl), (fx == 3'd0) ? 32'd0 : 32'(fx - 3'd1) & 32'd3);
      check_val("scandoubler", 32'(scandoubler), 32'((fx != 3'd0) || forced_scandoubler));
      check_val("hq2x", 32'(hq2x), 32'(fx == 3'd1));
    end
  endtask

  task automatic cpu_reset_test(input logic use_button);
    status  = '0;
    buttons = use_button ? 2'b10 : 2'b00;
    status[0] = ~use_button;
    wait_cpu_level(1'b1, 5);
    status  = '0;
    buttons = 2'b00;
    wait_cpu_level(1'b0, 6);
  endtask

  initial begin
    RESET              = 1'b1;
    pll_locked         = 1'b1;
    ps2_key            = '0;
    joystick_0         = '0;
    joystick_1         = '0;
    status             = '0;
    buttons            = 2'b00;
    forced_scandoubler = 1'b0;
    sdram_sz           = 2'b00;
    repeat (10) next_cycle();
    reset_release_test();
    lock_loss_test();
    key_test();
    joystick_test();
    options_test();
    cpu_reset_test(1'b0);
    cpu_reset_test(1'b1);
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

/* src.f */
ctrl_pkg.sv
pll_lock_watch.sv
reset_sync.sv
player_input.sv
option_decode.sv
core_ctrl_top.sv
tb_core_ctrl.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" && \
  verilator --binary --timing --assert --timescale 1ns/1ps -f src.f \
    --top-module tb_core_ctrl -o tb_core_ctrl && \
  ./obj_dir/tb_core_ctrl || exit 1
